// File: include/comp_cfg.svh
`ifndef COMP_CFG_SVH
`define COMP_CFG_SVH

// LocalLink bus
`define LL_DATA_W      32
`define LL_REM_W       4

// TX header layout
`define HDR_WORDS      8
`define HDR_FLAG_IDX   4
`define HDR_LEN_IDX    5
`define HDR_TASK_IDX   6
`define FLAG_W         3
`define TASK_W         10

// Channel buffer
`define FIFO_DEPTH     64
`define FIFO_AW        6
`define CNT_W          16

// CRC-32, MSB first
`define CRC_POLY       32'h04C1_1DB7
`define CRC_INIT       32'hFFFF_FFFF

// DCR slave
`define COMP_VERSION   32'h0102_0000
`define DCR_MAGIC      32'haa55_55aa
`define DCR_AW         10
`define DCR_ACK_W      1

`endif

// File: verilog/comp_pkg.sv
`default_nettype none

`include "comp_cfg.svh"

package comp_pkg;

   // TX beat from the DMA engine
   typedef struct packed {
      logic [`LL_DATA_W-1:0] data;
      logic [`LL_REM_W-1:0]  rem;
      logic                  sof_n;
      logic                  eof_n;
      logic                  sop_n;
      logic                  eop_n;
      logic                  src_rdy_n;
   } ll_tx_t;

   // RX beat back to the DMA engine
   typedef struct packed {
      logic [`LL_DATA_W-1:0] data;
      logic [`LL_REM_W-1:0]  rem;
      logic                  sof_n;
      logic                  eof_n;
      logic                  sop_n;
      logic                  eop_n;
      logic                  src_rdy_n;
   } ll_rx_t;

   typedef struct packed {
      logic [`DCR_AW-1:0] abus;
      logic [31:0]        dbus;
      logic               read;
      logic               write;
   } dcr_req_t;

   // Header fields captured per frame
   typedef struct packed {
      logic [`FLAG_W-1:0]    flags;
      logic [`LL_DATA_W-1:0] src_len;
      logic [`TASK_W-1:0]    task_index;
   } frame_info_t;

   typedef enum logic [3:0] {
      TX_IDLE    = 4'h0,
      TX_HDR     = 4'h1,
      TX_PAYLOAD = 4'h2,
      TX_TRAILER = 4'h3,
      TX_BUSY    = 4'h4
   } tx_state_e;

   typedef enum logic [3:0] {
      RX_IDLE    = 4'h0,
      RX_PAYLOAD = 4'h1,
      RX_APP1    = 4'h2,
      RX_APP2    = 4'h3,
      RX_APP3    = 4'h4,
      RX_APP4    = 4'h5
   } rx_state_e;

   typedef struct packed {
      tx_state_e          tx_state;
      rx_state_e          rx_state;
      logic [`CNT_W-1:0]  word_cnt;
      logic [`CNT_W-1:0]  byte_cnt;
      logic               busy;
   } status_t;

endpackage

`default_nettype wire

// File: verilog/payload_fifo.sv
`default_nettype none

`include "comp_cfg.svh"

module payload_fifo (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   push_i,
   input  wire logic [`LL_DATA_W-1:0]  push_data_i,
   input  wire logic                   pop_i,
   output logic [`LL_DATA_W-1:0]       pop_data_o,
   output logic                        empty_o,
   output logic                        full_o
);

   logic [`LL_DATA_W-1:0] mem [`FIFO_DEPTH];
   // Extra MSB tells full from empty
   logic [`FIFO_AW:0]     wr_ptr;
   logic [`FIFO_AW:0]     rd_ptr;

   assign empty_o = (wr_ptr == rd_ptr);
   assign full_o  = (wr_ptr[`FIFO_AW] != rd_ptr[`FIFO_AW]) &&
                    (wr_ptr[`FIFO_AW-1:0] == rd_ptr[`FIFO_AW-1:0]);

   // Head word is visible without a pop
   assign pop_data_o = mem[rd_ptr[`FIFO_AW-1:0]];

   always_ff @(posedge clk) begin
      if (push_i && !full_o) begin
         mem[wr_ptr[`FIFO_AW-1:0]] <= push_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push_i && !full_o) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_i && !empty_o) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/ll_crc.sv
`default_nettype none

`include "comp_cfg.svh"

module ll_crc (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   en_i,
   input  wire logic [`LL_DATA_W-1:0]  data_i,
   input  wire logic                   clear_i,
   output logic [31:0]                 crc_o
);

   // One full data word per step, MSB first, no reflection
   function automatic logic [31:0] crc_step(input logic [31:0] crc,
                                            input logic [`LL_DATA_W-1:0] d);
      logic [31:0] c;
      logic        fb;
      c = crc;
      for (int i = `LL_DATA_W - 1; i >= 0; i--) begin
         fb = c[31] ^ d[i];
         c  = {c[30:0], 1'b0};
         if (fb) begin
            c = c ^ `CRC_POLY;
         end
      end
      return c;
   endfunction

   always_ff @(posedge clk) begin
      if (!rst_n || clear_i) begin
         crc_o <= `CRC_INIT;
      end else if (en_i) begin
         crc_o <= crc_step(crc_o, data_i);
      end
   end

endmodule

`default_nettype wire

// File: verilog/ll_tx_parser.sv
`default_nettype none

`include "comp_cfg.svh"

module ll_tx_parser (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire comp_pkg::ll_tx_t       tx_i,
   input  wire logic                   full_i,
   input  wire logic                   rx_done_i,
   output logic                        tx_dst_rdy_n_o,
   output logic                        push_o,
   output logic [`LL_DATA_W-1:0]       push_data_o,
   output logic                        crc_en_o,
   output logic [`LL_DATA_W-1:0]       crc_data_o,
   output logic                        tx_done_o,
   output comp_pkg::frame_info_t       info_o,
   output logic [`CNT_W-1:0]           word_cnt_o,
   output logic [`CNT_W-1:0]           byte_cnt_o,
   output comp_pkg::tx_state_e         state_o
);

   import comp_pkg::*;

   localparam int HC_W = $clog2(`HDR_WORDS);
   localparam int VB_W = $clog2(`LL_REM_W + 1);

   tx_state_e              state;
   logic [HC_W-1:0]        hdr_cnt;
   logic                   beat;
   logic                   pay_beat;
   logic [`LL_DATA_W-1:0]  masked;
   logic [VB_W-1:0]        valid_bytes;

   // Buffer full only stalls payload, so the EOF word always gets through
   assign tx_dst_rdy_n_o = (state == TX_BUSY) || ((state == TX_PAYLOAD) && full_i);
   assign beat           = !tx_i.src_rdy_n && !tx_dst_rdy_n_o;
   assign pay_beat       = beat && (state == TX_PAYLOAD);
   assign tx_done_o      = beat && (state == TX_TRAILER) && !tx_i.eof_n;

   assign push_o      = pay_beat;
   assign push_data_o = masked;
   assign crc_en_o    = pay_beat;
   assign crc_data_o  = masked;
   assign state_o     = state;

   // REM bit i set means byte lane i is not valid
   always_comb begin
      masked      = tx_i.data;
      valid_bytes = VB_W'(`LL_REM_W);
      if (!tx_i.eop_n) begin
         for (int i = 0; i < `LL_REM_W; i++) begin
            if (tx_i.rem[i]) begin
               masked[8*i +: 8] = 8'h00;
               valid_bytes      = valid_bytes - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= TX_IDLE;
         hdr_cnt    <= '0;
         word_cnt_o <= '0;
         byte_cnt_o <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               // SOF word is header word 0
               if (beat && !tx_i.sof_n) begin
                  state      <= TX_HDR;
                  hdr_cnt    <= HC_W'(1);
                  word_cnt_o <= '0;
                  byte_cnt_o <= '0;
               end
            end
            TX_HDR: begin
               if (beat) begin
                  hdr_cnt <= hdr_cnt + 1'b1;
                  if (hdr_cnt == HC_W'(`HDR_WORDS - 1)) begin
                     state <= TX_PAYLOAD;
                  end
               end
            end
            TX_PAYLOAD: begin
               if (beat) begin
                  word_cnt_o <= word_cnt_o + 1'b1;
                  byte_cnt_o <= byte_cnt_o + `CNT_W'(valid_bytes);
                  if (!tx_i.eop_n) begin
                     state <= TX_TRAILER;
                  end
               end
            end
            TX_TRAILER: begin
               if (tx_done_o) begin
                  state <= TX_BUSY;
               end
            end
            TX_BUSY: begin
               if (rx_done_i) begin
                  state <= TX_IDLE;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (beat && (state == TX_HDR)) begin
         if (hdr_cnt == HC_W'(`HDR_FLAG_IDX)) begin
            info_o.flags <= tx_i.data[`LL_DATA_W-1 -: `FLAG_W];
         end
         if (hdr_cnt == HC_W'(`HDR_LEN_IDX)) begin
            info_o.src_len <= tx_i.data;
         end
         if (hdr_cnt == HC_W'(`HDR_TASK_IDX)) begin
            info_o.task_index <= tx_i.data[`TASK_W-1:0];
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/ll_rx_framer.sv
`default_nettype none

`include "comp_cfg.svh"

module ll_rx_framer (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   tx_done_i,
   input  wire comp_pkg::frame_info_t  info_i,
   input  wire logic [`CNT_W-1:0]      word_cnt_i,
   input  wire logic [`CNT_W-1:0]      byte_cnt_i,
   input  wire logic [31:0]            crc_i,
   input  wire logic [`LL_DATA_W-1:0]  pop_data_i,
   input  wire logic                   empty_i,
   input  wire logic                   rx_dst_rdy_n_i,
   output comp_pkg::ll_rx_t            rx_o,
   output logic                        pop_o,
   output logic                        rx_done_o,
   output comp_pkg::rx_state_e         state_o
);

   import comp_pkg::*;

   rx_state_e               state;
   logic [`CNT_W-1:0]       left;
   logic                    xfer;
   logic                    first_word;
   logic                    last_word;
   logic                    mismatch;
   logic [1:0]              pad_bytes;
   logic [`LL_REM_W-1:0]    last_rem;

   assign xfer       = !rx_o.src_rdy_n && !rx_dst_rdy_n_i;
   assign first_word = (left == word_cnt_i);
   assign last_word  = (left == `CNT_W'(1));
   assign mismatch   = ({{(`LL_DATA_W - `CNT_W){1'b0}}, byte_cnt_i} != info_i.src_len);

   // Last word REM follows from the byte count modulo the word size
   assign pad_bytes = ~byte_cnt_i[1:0] + 1'b1;
   assign last_rem  = ~({`LL_REM_W{1'b1}} << pad_bytes);

   assign pop_o     = (state == RX_PAYLOAD) && xfer;
   assign rx_done_o = (state == RX_APP4) && xfer;
   assign state_o   = state;

   always_comb begin
      rx_o      = '1;
      rx_o.data = '0;
      rx_o.rem  = '0;
      case (state)
         RX_PAYLOAD: begin
            rx_o.data      = pop_data_i;
            rx_o.src_rdy_n = empty_i;
            rx_o.sof_n     = !first_word;
            rx_o.sop_n     = !first_word;
            rx_o.eop_n     = !last_word;
            if (last_word) begin
               rx_o.rem = last_rem;
            end
         end
         RX_APP1: begin
            rx_o.src_rdy_n = 1'b0;
            rx_o.data = {info_i.flags, mismatch,
                         {(`LL_DATA_W - `FLAG_W - `TASK_W - 2){1'b0}},
                         1'b1, crc_i[`TASK_W-1:0]};
         end
         RX_APP2: begin
            rx_o.src_rdy_n = 1'b0;
            rx_o.data      = `LL_DATA_W'(byte_cnt_i);
         end
         RX_APP3: begin
            rx_o.src_rdy_n = 1'b0;
            rx_o.data      = {crc_i[31:`TASK_W], info_i.task_index};
         end
         RX_APP4: begin
            rx_o.src_rdy_n = 1'b0;
            rx_o.eof_n     = 1'b0;
            rx_o.data      = info_i.src_len;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= RX_IDLE;
         left  <= '0;
      end else begin
         case (state)
            RX_IDLE: begin
               if (tx_done_i) begin
                  left  <= word_cnt_i;
                  state <= RX_PAYLOAD;
               end
            end
            RX_PAYLOAD: begin
               if (xfer) begin
                  left <= left - 1'b1;
                  if (last_word) begin
                     state <= RX_APP1;
                  end
               end
            end
            RX_APP1: if (xfer) state <= RX_APP2;
            RX_APP2: if (xfer) state <= RX_APP3;
            RX_APP3: if (xfer) state <= RX_APP4;
            RX_APP4: if (xfer) state <= RX_IDLE;
            default: state <= RX_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/dcr_regs.sv
`default_nettype none

`include "comp_cfg.svh"

module dcr_regs (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire comp_pkg::dcr_req_t     dcr_i,
   input  wire comp_pkg::status_t      status_i,
   input  wire comp_pkg::frame_info_t  info_i,
   output logic [`DCR_ACK_W-1:0]       dcr_ack_o,
   output logic [31:0]                 dcr_rdata_o,
   output logic                        rst_engine_req_o
);

   logic [31:0] rd_mux;

   always_comb begin
      rd_mux = '0;
      case (dcr_i.abus[3:0])
         4'h0: begin
            rd_mux[31:28] = status_i.tx_state;
            rd_mux[27:24] = status_i.rx_state;
            rd_mux[0]     = status_i.busy;
         end
         4'h2: begin
            rd_mux[31 -: `FLAG_W]  = info_i.flags;
            rd_mux[`TASK_W-1:0]    = info_i.task_index;
         end
         4'h4: rd_mux = {status_i.word_cnt, status_i.byte_cnt};
         4'h5: rd_mux = info_i.src_len;
         4'he: rd_mux = `COMP_VERSION;
         4'hf: rd_mux = `DCR_MAGIC;
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dcr_ack_o        <= '0;
         rst_engine_req_o <= 1'b0;
      end else begin
         dcr_ack_o        <= {`DCR_ACK_W{dcr_i.read || dcr_i.write}};
         // Engine reset request on write of bit 31 to register 0
         rst_engine_req_o <= dcr_i.write && (dcr_i.abus == '0) && dcr_i.dbus[31];
      end
   end

   always_ff @(posedge clk) begin
      if (dcr_i.read) begin
         dcr_rdata_o <= rd_mux;
      end
   end

endmodule

`default_nettype wire

// File: verilog/comp_unit.sv
`default_nettype none

`include "comp_cfg.svh"

module comp_unit (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire comp_pkg::ll_tx_t    tx_i,
   input  wire logic                rx_dst_rdy_n_i,
   input  wire comp_pkg::dcr_req_t  dcr_i,
   output logic                     tx_dst_rdy_n_o,
   output comp_pkg::ll_rx_t         rx_o,
   output logic [`DCR_ACK_W-1:0]    dcr_ack_o,
   output logic [31:0]              dcr_rdata_o,
   output logic                     rst_engine_req_o
);

   import comp_pkg::*;

   logic                   push;
   logic [`LL_DATA_W-1:0]  push_data;
   logic                   pop;
   logic [`LL_DATA_W-1:0]  pop_data;
   logic                   empty;
   logic                   full;
   logic                   crc_en;
   logic [`LL_DATA_W-1:0]  crc_data;
   logic [31:0]            crc;
   logic                   tx_done;
   logic                   rx_done;
   frame_info_t            info;
   logic [`CNT_W-1:0]      word_cnt;
   logic [`CNT_W-1:0]      byte_cnt;
   tx_state_e              tx_state;
   rx_state_e              rx_state;
   status_t                status;

   assign status = '{tx_state: tx_state,
                     rx_state: rx_state,
                     word_cnt: word_cnt,
                     byte_cnt: byte_cnt,
                     busy:     (tx_state == TX_BUSY)};

   ll_tx_parser ll_tx_parser_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .tx_i           (tx_i),
      .full_i         (full),
      .rx_done_i      (rx_done),
      .tx_dst_rdy_n_o (tx_dst_rdy_n_o),
      .push_o         (push),
      .push_data_o    (push_data),
      .crc_en_o       (crc_en),
      .crc_data_o     (crc_data),
      .tx_done_o      (tx_done),
      .info_o         (info),
      .word_cnt_o     (word_cnt),
      .byte_cnt_o     (byte_cnt),
      .state_o        (tx_state)
   );

   payload_fifo payload_fifo_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .push_i      (push),
      .push_data_i (push_data),
      .pop_i       (pop),
      .pop_data_o  (pop_data),
      .empty_o     (empty),
      .full_o      (full)
   );

   // CRC restarts once the RX frame has gone out
   ll_crc ll_crc_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .en_i    (crc_en),
      .data_i  (crc_data),
      .clear_i (rx_done),
      .crc_o   (crc)
   );

   ll_rx_framer ll_rx_framer_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .tx_done_i      (tx_done),
      .info_i         (info),
      .word_cnt_i     (word_cnt),
      .byte_cnt_i     (byte_cnt),
      .crc_i          (crc),
      .pop_data_i     (pop_data),
      .empty_i        (empty),
      .rx_dst_rdy_n_i (rx_dst_rdy_n_i),
      .rx_o           (rx_o),
      .pop_o          (pop),
      .rx_done_o      (rx_done),
      .state_o        (rx_state)
   );

   dcr_regs dcr_regs_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .dcr_i            (dcr_i),
      .status_i         (status),
      .info_i           (info),
      .dcr_ack_o        (dcr_ack_o),
      .dcr_rdata_o      (dcr_rdata_o),
      .rst_engine_req_o (rst_engine_req_o)
   );

endmodule

`default_nettype wire

// File: sim/tb_comp_unit.sv
`default_nettype none

`include "comp_cfg.svh"

module tb_comp_unit;

   import comp_pkg::*;

   localparam int          NUM_FRAMES  = 20;
   localparam int          TIMEOUT_CYC = NUM_FRAMES * 300 + 1000;
   localparam logic [31:0] SEED        = 32'h22d5_84a0;

   logic                  clk = 1'b0;
   logic                  rst_n;
   ll_tx_t                tx_i;
   logic                  rx_dst_rdy_n_i = 1'b1;
   dcr_req_t              dcr_i;
   logic                  tx_dst_rdy_n_o;
   ll_rx_t                rx_o;
   logic [`DCR_ACK_W-1:0] dcr_ack_o;
   logic [31:0]           dcr_rdata_o;
   logic                  rst_engine_req_o;

   int                    errors = 0;
   int                    checks = 0;
   int                    cycles = 0;
   int                    rx_frames = 0;
   logic [31:0]           rdy_seed;
   logic [31:0]           rdy_lfsr;
   // Expected RX beats, ctrl is {rem, sof_n, eof_n, sop_n, eop_n}
   logic [31:0]           exp_data[$];
   logic [7:0]            exp_ctrl[$];
   logic                  awaiting_rx;
   logic                  tx_eof_d;
   logic                  stalled;
   ll_rx_t                held;
   logic [31:0]           last_src_len;
   logic [2:0]            last_flags;
   logic [9:0]            last_task;

   comp_unit comp_unit_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .tx_i             (tx_i),
      .rx_dst_rdy_n_i   (rx_dst_rdy_n_i),
      .dcr_i            (dcr_i),
      .tx_dst_rdy_n_o   (tx_dst_rdy_n_o),
      .rx_o             (rx_o),
      .dcr_ack_o        (dcr_ack_o),
      .dcr_rdata_o      (dcr_rdata_o),
      .rst_engine_req_o (rst_engine_req_o)
   );

   always #10 clk = ~clk;

   task automatic compare_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("ERROR %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic expect_true(input logic cond, input string what);
      checks++;
      assert (cond === 1'b1) else begin
         errors++;
         $display("%s", what);
      end
   endtask

   // Word xored in first, then 32 shifts through the polynomial
   function automatic logic [31:0] ref_crc(input logic [31:0] crc, input logic [31:0] word);
      logic [31:0] r;
      r = crc ^ word;
      repeat (32) begin
         if (r[31]) begin
            r = (r << 1) ^ `CRC_POLY;
         end else begin
            r = r << 1;
         end
      end
      return r;
   endfunction

   function automatic ll_tx_t quiet_beat();
      ll_tx_t b;
      b      = '1;
      b.data = '0;
      b.rem  = '0;
      return b;
   endfunction

   // Present one beat, optionally after a gap, and hold it until taken
   task automatic send_beat(input ll_tx_t beat);
      int gap;
      gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
      if (gap != 0) begin
         tx_i <= quiet_beat();
         repeat (gap) @(posedge clk);
      end
      tx_i <= beat;
      @(posedge clk);
      while (tx_dst_rdy_n_o) begin
         @(posedge clk);
      end
   endtask

   task automatic run_frame();
      int          n;
      int          sel;
      int          bytes;
      logic [3:0]  rem;
      logic [31:0] hdr[8];
      logic [31:0] payload[$];
      logic [31:0] word;
      logic [31:0] crc;
      logic [31:0] src_len;
      logic [31:0] app1;
      logic        last;
      ll_tx_t      beat;
      n   = $urandom_range(1, `FIFO_DEPTH);
      sel = $urandom_range(0, 3);
      case (sel)
         0: rem = 4'b0000;
         1: rem = 4'b0001;
         2: rem = 4'b0011;
         default: rem = 4'b0111;
      endcase
      bytes = 4 * (n - 1) + (4 - sel);
      for (int i = 0; i < 8; i++) begin
         hdr[i] = $urandom;
      end
      if ($urandom_range(0, 1) == 1) begin
         src_len = 32'(bytes);
      end else begin
         src_len = $urandom;
      end
      hdr[5] = src_len;
      crc    = `CRC_INIT;
      for (int i = 0; i < n; i++) begin
         last = (i == n - 1);
         word = $urandom;
         payload.push_back(word);
         if (last) begin
            word = word & (32'hffff_ffff << (8 * sel));
         end
         crc = ref_crc(crc, word);
         exp_data.push_back(word);
         exp_ctrl.push_back({last ? rem : 4'h0, i != 0, 1'b1, i != 0, !last});
      end
      app1       = '0;
      app1[31:29] = hdr[4][31:29];
      app1[28]   = (src_len != 32'(bytes));
      app1[10]   = 1'b1;
      app1[9:0]  = crc[9:0];
      exp_data.push_back(app1);
      exp_data.push_back(32'(bytes));
      exp_data.push_back({crc[31:10], hdr[6][9:0]});
      exp_data.push_back(src_len);
      exp_ctrl.push_back(8'h0f);
      exp_ctrl.push_back(8'h0f);
      exp_ctrl.push_back(8'h0f);
      exp_ctrl.push_back(8'h0b);
      last_src_len = src_len;
      last_flags   = hdr[4][31:29];
      last_task    = hdr[6][9:0];
      for (int i = 0; i < 8; i++) begin
         beat           = quiet_beat();
         beat.data      = hdr[i];
         beat.src_rdy_n = 1'b0;
         beat.sof_n     = (i != 0);
         send_beat(beat);
      end
      for (int i = 0; i < n; i++) begin
         beat           = quiet_beat();
         beat.data      = payload[i];
         beat.src_rdy_n = 1'b0;
         beat.sop_n     = (i != 0);
         beat.eop_n     = (i != n - 1);
         beat.rem       = (i == n - 1) ? rem : 4'h0;
         send_beat(beat);
      end
      beat           = quiet_beat();
      beat.data      = $urandom;
      beat.src_rdy_n = 1'b0;
      beat.eof_n     = 1'b0;
      send_beat(beat);
   endtask

   task automatic dcr_read(input logic [3:0] addr, input logic [31:0] exp, input string name);
      dcr_i <= '{abus: {6'h0, addr}, dbus: 32'h0, read: 1'b1, write: 1'b0};
      @(posedge clk);
      dcr_i <= '0;
      expect_true(dcr_ack_o == 1'b0, "DCR ack came in the same cycle as the read strobe");
      @(posedge clk);
      expect_true(dcr_ack_o == 1'b1, "DCR ack missing in the cycle after the read strobe");
      compare_word(name, dcr_rdata_o, exp);
   endtask

   task automatic engine_reset_check();
      dcr_i <= '{abus: '0, dbus: 32'h8000_0000, read: 1'b0, write: 1'b1};
      @(posedge clk);
      dcr_i <= '0;
      expect_true(!rst_engine_req_o, "Engine reset request rose before the write completed");
      @(posedge clk);
      expect_true(rst_engine_req_o, "Engine reset request missing after the write");
      expect_true(dcr_ack_o == 1'b1, "DCR ack missing in the cycle after the write strobe");
      @(posedge clk);
      expect_true(!rst_engine_req_o, "Engine reset request lasted more than one cycle");
   endtask

   // Random RX back-pressure, about one stall cycle in four
   always @(posedge clk) begin
      if (!rst_n) begin
         rdy_lfsr       <= rdy_seed | 32'h1;
         rx_dst_rdy_n_i <= 1'b1;
      end else begin
         rdy_lfsr       <= {rdy_lfsr[30:0],
                            rdy_lfsr[31] ^ rdy_lfsr[21] ^ rdy_lfsr[1] ^ rdy_lfsr[0]};
         rx_dst_rdy_n_i <= (rdy_lfsr[1:0] == 2'b00);
      end
   end

   always @(posedge clk) begin
      if (!rst_n) begin
         awaiting_rx <= 1'b0;
         tx_eof_d    <= 1'b0;
         stalled     <= 1'b0;
      end else begin
         if (tx_eof_d) begin
            expect_true(!rx_o.src_rdy_n, "RX frame did not start the cycle after TX EOF");
         end
         tx_eof_d <= 1'b0;
         if (!tx_i.src_rdy_n && !tx_dst_rdy_n_o) begin
            expect_true(!awaiting_rx, "TX beat accepted while the previous RX frame was pending");
            if (!tx_i.eof_n) begin
               awaiting_rx <= 1'b1;
               tx_eof_d    <= 1'b1;
            end
         end
         if (stalled) begin
            expect_true(rx_o === held, "RX word changed while the sink was stalling");
         end
         stalled <= !rx_o.src_rdy_n && rx_dst_rdy_n_i;
         held    <= rx_o;
         if (!rx_o.src_rdy_n && !rx_dst_rdy_n_i) begin
            if (exp_data.size() == 0) begin
               expect_true(1'b0, "RX beat transferred with no frame expected");
            end else begin
               compare_word("rx_o.data", rx_o.data, exp_data.pop_front());
               compare_word("rx_o {rem,sof_n,eof_n,sop_n,eop_n}",
                            {24'h0, rx_o.rem, rx_o.sof_n, rx_o.eof_n, rx_o.sop_n, rx_o.eop_n},
                            {24'h0, exp_ctrl.pop_front()});
               if (!rx_o.eof_n) begin
                  awaiting_rx <= 1'b0;
                  rx_frames   <= rx_frames + 1;
               end
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYC) begin
         $display("Run stopped after %0d cycles without finishing", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      void'($urandom(SEED));
      rdy_seed = $urandom;
      rst_n <= 1'b0;
      tx_i  <= quiet_beat();
      dcr_i <= '0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      compare_word("tx_dst_rdy_n_o", 32'(tx_dst_rdy_n_o), 32'h0);
      compare_word("rx_o {sof_n,eof_n,sop_n,eop_n,src_rdy_n}",
                   {27'h0, rx_o.sof_n, rx_o.eof_n, rx_o.sop_n, rx_o.eop_n, rx_o.src_rdy_n},
                   32'h1f);
      compare_word("dcr_ack_o", 32'(dcr_ack_o), 32'h0);
      compare_word("rst_engine_req_o", 32'(rst_engine_req_o), 32'h0);
      dcr_read(4'he, `COMP_VERSION, "dcr_rdata_o (version)");
      dcr_read(4'hf, `DCR_MAGIC, "dcr_rdata_o (magic)");
      engine_reset_check();
      for (int f = 0; f < NUM_FRAMES; f++) begin
         run_frame();
      end
      tx_i <= quiet_beat();
      while (exp_data.size() != 0) begin
         @(posedge clk);
      end
      @(posedge clk);
      compare_word("rx frame count", 32'(rx_frames), 32'(NUM_FRAMES));
      dcr_read(4'h5, last_src_len, "dcr_rdata_o (src_len)");
      dcr_read(4'h2, {last_flags, 19'h0, last_task}, "dcr_rdata_o (flags/task)");
      $display("checks %0d errors %0d frames %0d", checks, errors, rx_frames);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
verilog/comp_pkg.sv
verilog/payload_fifo.sv
verilog/ll_crc.sv
verilog/ll_tx_parser.sv
verilog/ll_rx_framer.sv
verilog/dcr_regs.sv
verilog/comp_unit.sv
sim/tb_comp_unit.sv

// File: Bender.yml
package:
  name: comp_unit

sources:
  - include_dirs:
      - include
    files:
      - verilog/comp_pkg.sv
      - verilog/payload_fifo.sv
      - verilog/ll_crc.sv
      - verilog/ll_tx_parser.sv
      - verilog/ll_rx_framer.sv
      - verilog/dcr_regs.sv
      - verilog/comp_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_comp_unit.sv
